/* wed_pkg.sv */
// WED fetch shared definitions
// Tag and command codes, cache line sizes, command queue geometry,
// fetch FSM state codes and the two views of the 128-byte WED line

package wed_pkg;

  // ----------------------------------------------------------------------
  // Host bus codes
  // ----------------------------------------------------------------------
  localparam logic [7:0] WED_TAG     = 8'h2a;  // Marks all WED traffic
  localparam logic [3:0] CMD_READ_CL = 4'h1;   // Full cache line read

  localparam logic [1:0] RESP_DONE   = 2'd0;
  localparam logic [1:0] RESP_FAILED = 2'd1;   // Read must be sent again

  // ----------------------------------------------------------------------
  // Line geometry
  // ----------------------------------------------------------------------
  localparam int CL_BYTES     = 128;
  localparam int CL_BITS      = 1024;
  localparam int CL_HALF_BITS = 512;           // One data beat

  // Command queue
  localparam int CMD_FIFO_DEPTH  = 4;
  localparam int CMD_FIFO_ALFULL = 3;          // Stop issuing at this level
  localparam int CMD_PTR_BITS    = $clog2(CMD_FIFO_DEPTH);
  localparam int CMD_CNT_BITS    = $clog2(CMD_FIFO_DEPTH + 1);
  // address + size + command + tag
  localparam int CMD_ENTRY_BITS  = 64 + 12 + 4 + 8;

  // Fetch FSM states
  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_ISSUE = 2'd1;      // Command offered to queue
  localparam logic [1:0] ST_WAIT  = 2'd2;      // Data and response pending
  localparam logic [1:0] ST_DONE  = 2'd3;

  // Used descriptor bits, the rest of the line is padding
  localparam int WED_USED_BITS = 4 * 32 + 3 * 64;

  // ----------------------------------------------------------------------
  // Descriptor layout, first field at the top of the line
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [31:0] job_id;
    logic [31:0] vertex_count;
    logic [31:0] edge_count;
    logic [31:0] flags;
    logic [63:0] vertex_array_addr;
    logic [63:0] edge_array_addr;
    logic [63:0] result_addr;
    logic [CL_BITS-WED_USED_BITS-1:0] reserved;  // Pad to a full line
  } wed_desc_t;

  // Same 1024 bits seen as fields or as the two returned beats
  typedef union packed {
    wed_desc_t                       desc;
    logic [1:0][CL_HALF_BITS-1:0]    half;  // half[1] is the upper beat
  } wed_line_u;

endpackage

/* wed_bus_if.sv */
// WED fetch internal buses
// Command stream from the fetch FSM into the command queue,
// and the tag-filtered half-line data stream back to the FSM

interface cmd_stream_if;
  logic        valid;
  logic        ready;    // Queue has room
  logic [63:0] address;
  logic [11:0] size;     // Bytes
  logic [3:0]  command;
  logic [7:0]  tag;

  modport source (output valid, address, size, command, tag, input ready);
  modport sink   (input valid, address, size, command, tag, output ready);
endinterface

interface rd_data_if;
  import wed_pkg::*;

  logic                    valid;  // No back-pressure on this path
  logic [7:0]              tag;
  logic                    half;   // 1 selects the upper beat
  logic [CL_HALF_BITS-1:0] data;

  modport source (output valid, tag, half, data);
  modport sink   (input valid, tag, half, data);
endinterface

/* command_fifo.sv */
// Command queue
// Four-entry circular buffer between the fetch FSM and the host
// command port. Head entry sits in output flops, almost_full tells
// the producer to hold off before the queue runs out of room.

module command_fifo (
  input  logic        clock,
  input  logic        rstn,
  cmd_stream_if.sink  in,
  output logic        out_valid,
  input  logic        out_ready,
  output logic [63:0] out_address,
  output logic [11:0] out_size,
  output logic [3:0]  out_command,
  output logic [7:0]  out_tag,
  output logic        almost_full
);
  import wed_pkg::*;

  logic [CMD_ENTRY_BITS-1:0] mem [CMD_FIFO_DEPTH];
  logic [CMD_PTR_BITS-1:0]   wr_ptr;
  logic [CMD_PTR_BITS-1:0]   rd_ptr;
  logic [CMD_PTR_BITS-1:0]   rd_ptr_next;
  logic [CMD_CNT_BITS-1:0]   count;      // Entries held
  logic [CMD_CNT_BITS-1:0]   count_next;
  logic [CMD_ENTRY_BITS-1:0] in_entry;
  logic [CMD_ENTRY_BITS-1:0] head_next;
  logic                      push;
  logic                      pop;
  logic                      full;

  // ----------------------------------------------------------------------
  // Occupancy and handshakes
  // ----------------------------------------------------------------------
  assign in_entry    = {in.address, in.size, in.command, in.tag};
  assign full        = (count == CMD_CNT_BITS'(CMD_FIFO_DEPTH));
  assign in.ready    = ~full;
  assign almost_full = (count >= CMD_CNT_BITS'(CMD_FIFO_ALFULL));

  assign push = in.valid & ~full;
  assign pop  = out_valid & out_ready;   // Host took the head

  assign rd_ptr_next = rd_ptr + CMD_PTR_BITS'(pop);
  assign count_next  = count + CMD_CNT_BITS'(push) - CMD_CNT_BITS'(pop);

  // Next head comes straight from the input when the queue drains to it
  assign head_next = (count == CMD_CNT_BITS'(pop)) ? in_entry : mem[rd_ptr_next];

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      out_valid <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
      rd_ptr    <= rd_ptr_next;
      count     <= count_next;
      out_valid <= (count_next != '0);
    end
  end

  // Storage and head register
  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr] <= in_entry;
    end
    {out_address, out_size, out_command, out_tag} <= head_next;  // Holds when stalled
  end

endmodule

/* response_router.sv */
// Response router
// Passes on only the returned data beats and completion responses
// that carry the WED tag. Everything else on the host return path
// is dropped here, so the fetch FSM never looks at a tag.

module response_router (
  // Data beats from host memory
  input  logic                             rd_valid,
  input  logic [7:0]                       rd_tag,
  input  logic                             rd_half,
  input  logic [wed_pkg::CL_HALF_BITS-1:0] rd_data,
  // Completion responses from host memory
  input  logic                             rsp_valid,
  input  logic [7:0]                       rsp_tag,
  input  logic [1:0]                       rsp_code,
  // Filtered toward the fetch FSM
  rd_data_if.source                        data_out,
  output logic                             resp_valid,
  output logic [1:0]                       resp_code
);
  import wed_pkg::*;

  logic rd_match;
  logic rsp_match;

  // ----------------------------------------------------------------------
  // Tag compare
  // ----------------------------------------------------------------------
  assign rd_match  = (rd_tag == WED_TAG);
  assign rsp_match = (rsp_tag == WED_TAG);

  // Beat forward, same cycle
  assign data_out.valid = rd_valid & rd_match;
  assign data_out.tag   = rd_tag;
  assign data_out.half  = rd_half;    // Selects the line half to write
  assign data_out.data  = rd_data;

  // Response forward
  assign resp_valid = rsp_valid & rsp_match;
  assign resp_code  = rsp_code;       // Only meaningful with resp_valid

endmodule

/* wed_control.sv */
// WED fetch control
// Issues one cache line read for the descriptor address, collects
// the two returned beats into a line register and publishes the
// decoded descriptor on DONE. A FAILED response sends the read again.
// Descriptor stays valid until enable drops.

module wed_control (
  input  logic               clock,
  input  logic               rstn,
  input  logic               enable,
  input  logic [63:0]        wed_address,
  input  logic               almost_full,   // From the command queue
  cmd_stream_if.source       cmd,
  rd_data_if.sink            data_in,
  input  logic               resp_valid,
  input  logic [1:0]         resp_code,
  output logic               wed_valid,
  output wed_pkg::wed_desc_t wed_desc
);
  import wed_pkg::*;

  logic        enabled;      // Registered enable
  logic [1:0]  state;
  logic [1:0]  next_state;
  logic [1:0]  half_seen;    // Beats received for this attempt
  logic [1:0]  half_we;      // Per-half write strobes
  logic        line_full;
  logic [63:0] req_address;  // Held for a retry
  wed_line_u   line_q;

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled <= 1'b0;
    end else begin
      enabled <= enable;
    end
  end

  // ----------------------------------------------------------------------
  // Beat strobes
  // ----------------------------------------------------------------------
  assign half_we[0] = data_in.valid & ~data_in.half & (state == ST_WAIT);
  assign half_we[1] = data_in.valid & data_in.half & (state == ST_WAIT);
  // Count a beat landing in the response cycle too
  assign line_full  = &(half_seen | half_we);

  // ----------------------------------------------------------------------
  // Next state
  // ----------------------------------------------------------------------
  always_comb begin
    next_state = state;
    case (state)
      ST_IDLE: begin
        if (enabled && !wed_valid && !almost_full) next_state = ST_ISSUE;
      end
      ST_ISSUE: begin
        if (cmd.ready) next_state = ST_WAIT;  // Queue took the read
      end
      ST_WAIT: begin
        if (resp_valid) begin
          if (!enabled) begin
            next_state = ST_IDLE;             // Job withdrawn, drop result
          end else begin
            case (resp_code)
              RESP_DONE:   next_state = line_full ? ST_DONE : ST_ISSUE;
              RESP_FAILED: next_state = ST_ISSUE;
              default:     next_state = ST_IDLE;  // Unknown code, restart
            endcase
          end
        end
      end
      ST_DONE: begin
        next_state = ST_IDLE;  // wed_valid keeps IDLE quiet
      end
      default: begin
        next_state = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      state     <= ST_IDLE;
      wed_valid <= 1'b0;
      half_seen <= '0;
    end else begin
      state <= next_state;
      if (!enabled) begin
        wed_valid <= 1'b0;
      end else if (state == ST_WAIT && next_state == ST_DONE) begin
        wed_valid <= 1'b1;  // One cycle after the DONE response
      end
      if (next_state == ST_ISSUE) begin
        half_seen <= '0;    // Fresh attempt
      end else begin
        half_seen <= half_seen | half_we;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Request and line payload
  // ----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (state == ST_IDLE && next_state == ST_ISSUE) begin
      req_address <= wed_address;
    end
    if (!enabled) begin
      line_q <= '0;
    end else begin
      if (half_we[0]) line_q.half[0] <= data_in.data;
      if (half_we[1]) line_q.half[1] <= data_in.data;
    end
  end

  // Read command, valid held until the queue accepts
  assign cmd.valid   = (state == ST_ISSUE);
  assign cmd.address = req_address;
  assign cmd.size    = 12'(CL_BYTES);
  assign cmd.command = CMD_READ_CL;
  assign cmd.tag     = WED_TAG;

  assign wed_desc = line_q.desc;  // Field view of the assembled line

endmodule

/* wed_fetch_top.sv */
// WED fetch front end
// Fetch FSM, command queue toward host memory and tag router on the
// return path, all exposed as plain host and control ports

module wed_fetch_top (
  input  logic                             clock,
  input  logic                             rstn,
  // Control
  input  logic                             enable,
  input  logic [63:0]                      wed_address,
  output logic                             wed_valid,
  output wed_pkg::wed_desc_t               wed_desc,
  // Commands toward host memory
  output logic                             cmd_valid,
  input  logic                             cmd_ready,
  output logic [63:0]                      cmd_address,
  output logic [11:0]                      cmd_size,
  output logic [3:0]                       cmd_command,
  output logic [7:0]                       cmd_tag,
  // Returned data beats
  input  logic                             rd_valid,
  input  logic [7:0]                       rd_tag,
  input  logic                             rd_half,
  input  logic [wed_pkg::CL_HALF_BITS-1:0] rd_data,
  // Completion responses
  input  logic                             rsp_valid,
  input  logic [7:0]                       rsp_tag,
  input  logic [1:0]                       rsp_code
);

  logic       almost_full;
  logic       resp_valid;  // WED responses only
  logic [1:0] resp_code;

  cmd_stream_if cmd_bus ();
  rd_data_if    rd_bus ();

  // ----------------------------------------------------------------------
  // Fetch FSM
  // ----------------------------------------------------------------------
  wed_control u_wed_control (
    .clock       (clock),
    .rstn        (rstn),
    .enable      (enable),
    .wed_address (wed_address),
    .almost_full (almost_full),
    .cmd         (cmd_bus.source),
    .data_in     (rd_bus.sink),
    .resp_valid  (resp_valid),
    .resp_code   (resp_code),
    .wed_valid   (wed_valid),
    .wed_desc    (wed_desc)
  );

  // Commands out to the host port
  command_fifo u_cmd_fifo (
    .clock       (clock),
    .rstn        (rstn),
    .in          (cmd_bus.sink),
    .out_valid   (cmd_valid),
    .out_ready   (cmd_ready),
    .out_address (cmd_address),
    .out_size    (cmd_size),
    .out_command (cmd_command),
    .out_tag     (cmd_tag),
    .almost_full (almost_full)
  );

  // Return path filter
  response_router u_router (
    .rd_valid   (rd_valid),
    .rd_tag     (rd_tag),
    .rd_half    (rd_half),
    .rd_data    (rd_data),
    .rsp_valid  (rsp_valid),
    .rsp_tag    (rsp_tag),
    .rsp_code   (rsp_code),
    .data_out   (rd_bus.source),
    .resp_valid (resp_valid),
    .resp_code  (resp_code)
  );

endmodule

/* wed_checker.sv */
// WED fetch checker
// Watches the host command port, the completion responses and the
// descriptor outputs, compares them with the current case and counts
// every mismatch

module wed_checker (
  input  logic               clock, rstn, enable,
  input  logic               cmd_valid, cmd_ready,
  input  logic [63:0]        cmd_address,
  input  logic [11:0]        cmd_size,
  input  logic [3:0]         cmd_command,
  input  logic [7:0]         cmd_tag,
  input  logic               rsp_valid,
  input  logic [7:0]         rsp_tag,
  input  logic [1:0]         rsp_code,
  input  logic               wed_valid,
  input  wed_pkg::wed_desc_t wed_desc,
  input  logic [63:0]        exp_address,
  input  logic [511:0]       exp_upper, exp_lower,
  input  logic               exp_fail,     // Two reads expected
  output int                 error_count
);
  timeunit 1ns;
  timeprecision 100ps;
  import wed_pkg::*;

  // Descriptor layout with the first field at the top of the line
  typedef struct packed {
    logic [31:0]  job_id;
    logic [31:0]  vertex_count;
    logic [31:0]  edge_count;
    logic [31:0]  flags;
    logic [63:0]  vertex_array_addr;
    logic [63:0]  edge_array_addr;
    logic [63:0]  result_addr;
    logic [703:0] reserved;
  } exp_desc_t;

  exp_desc_t   exp;
  int          cmd_count;    // Commands taken this enable session
  int          low_cycles;   // Sampled edges with enable low
  logic        stalled;      // Command offered but refused last edge
  logic        done_seen;    // WED DONE response last edge
  logic        wed_valid_q;
  logic [87:0] stalled_cmd;

  assign exp = {exp_upper, exp_lower};

  task automatic report_error(input string msg);
    $display("Error %t: %s", $time, msg);
    error_count++;
  endtask

  task automatic check_desc();
    if (wed_desc.job_id !== exp.job_id)
      report_error($sformatf("job_id %h, expected %h", wed_desc.job_id, exp.job_id));
    if (wed_desc.vertex_count !== exp.vertex_count)
      report_error($sformatf("vertex_count %h, expected %h", wed_desc.vertex_count,
                             exp.vertex_count));
    if (wed_desc.edge_count !== exp.edge_count)
      report_error($sformatf("edge_count %h, expected %h", wed_desc.edge_count, exp.edge_count));
    if (wed_desc.flags !== exp.flags)
      report_error($sformatf("flags %h, expected %h", wed_desc.flags, exp.flags));
    if (wed_desc.vertex_array_addr !== exp.vertex_array_addr)
      report_error("vertex_array_addr differs from the case data");
    if (wed_desc.edge_array_addr !== exp.edge_array_addr)
      report_error("edge_array_addr differs from the case data");
    if (wed_desc.result_addr !== exp.result_addr)
      report_error("result_addr differs from the case data");
    if (wed_desc.reserved !== exp.reserved)
      report_error("reserved bits differ from the case data");
  endtask

  always @(posedge clock) begin
    if (!rstn) begin
      error_count = 0;
      cmd_count   = 0;
      low_cycles  = 0;
      stalled     = 1'b0;
      done_seen   = 1'b0;
      wed_valid_q = 1'b0;
    end else begin
      // -------------------------------------------------------------------
      // Command port
      // -------------------------------------------------------------------
      if (cmd_valid && cmd_ready) begin
        cmd_count++;
        if (cmd_address !== exp_address)
          report_error($sformatf("command address %h, expected %h", cmd_address, exp_address));
        if (cmd_size !== 12'd128 || cmd_command !== CMD_READ_CL || cmd_tag !== WED_TAG)
          report_error($sformatf("command size %0d code %h tag %h", cmd_size, cmd_command,
                                 cmd_tag));
        if (wed_valid) report_error("command issued while descriptor valid");
      end
      if (stalled && (!cmd_valid || {cmd_address, cmd_size, cmd_command, cmd_tag} !== stalled_cmd))
        report_error("command dropped or changed under back-pressure");
      if (low_cycles >= 2 && (cmd_valid || wed_valid))
        report_error("outputs active with enable low");

      // Descriptor publish one cycle after DONE
      if (done_seen && !wed_valid) report_error("wed_valid not high one cycle after DONE");
      if (wed_valid && !wed_valid_q) begin
        if (!done_seen) report_error("wed_valid rose without a DONE response");
        if (cmd_count != (exp_fail ? 2 : 1))
          report_error($sformatf("%0d read commands for this case", cmd_count));
      end
      if (wed_valid) check_desc();  // Fields hold while published
      if (!wed_valid && wed_valid_q && low_cycles == 0)
        report_error("wed_valid dropped while enable high");

      // State for the next edge
      stalled     = cmd_valid && !cmd_ready;
      stalled_cmd = {cmd_address, cmd_size, cmd_command, cmd_tag};
      done_seen   = rsp_valid && rsp_tag == WED_TAG && rsp_code == RESP_DONE && enable;
      wed_valid_q = wed_valid;
      if (enable) begin
        low_cycles = 0;
      end else begin
        cmd_count = 0;   // Next session starts clean
        if (low_cycles < 3) low_cycles++;
      end
    end
  end

endmodule

/* tb_wed_fetch.sv */
// WED fetch testbench
// Host memory model that serves each descriptor read from the cases
// file, with random command back-pressure, stray tags and retries

module tb_wed_fetch;
  timeunit 1ns;
  timeprecision 100ps;
  import wed_pkg::*;

  localparam int MAX_WAIT = 2000;  // Cycles per wait loop

  typedef struct {
    logic [63:0]  address;
    logic [511:0] upper;       // Holds the descriptor fields
    logic [511:0] lower;
    logic         fail_first;  // First read answered FAILED
  } wed_case_t;

  logic         clock = 1'b0;
  logic         rstn, enable, wed_valid;
  logic [63:0]  wed_address, cmd_address;
  wed_desc_t    wed_desc;
  logic         cmd_valid, cmd_ready, rd_valid, rd_half, rsp_valid;
  logic [11:0]  cmd_size;
  logic [3:0]   cmd_command;
  logic [7:0]   cmd_tag, rd_tag, rsp_tag;
  logic [511:0] rd_data;
  logic [1:0]   rsp_code;
  wed_case_t    cases[$];
  wed_case_t    cur;          // Case under test, seen by the checker
  int           error_count;
  int           timeout_count = 0;
  int           file_errors = 0;

  always #4 clock = ~clock;  // 8 ns period

  wed_fetch_top dut (.*);

  wed_checker chk (
    .*,
    .exp_address (cur.address),
    .exp_upper   (cur.upper),
    .exp_lower   (cur.lower),
    .exp_fail    (cur.fail_first)
  );

  // Inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge clock);
    #1;
  endtask

  task automatic load_cases();
    int               fd;
    int               code;
    wed_case_t        c;
    logic [8*120-1:0] header;
    fd = $fopen("wed_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open wed_cases.txt");
      file_errors++;
      return;
    end
    void'($fgets(header, fd));  // Two column description lines
    void'($fgets(header, fd));
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%h %h %h %h\n", c.address, c.upper, c.lower, c.fail_first);
      if (code != 4) break;
      cases.push_back(c);
    end
    $fclose(fd);
    if (cases.size() == 0) begin
      $display("No cases found in wed_cases.txt");
      file_errors++;
    end
  endtask

  // ----------------------------------------------------------------------
  // Host memory model
  // ----------------------------------------------------------------------
  task automatic wait_command(output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < MAX_WAIT && !ok; n++) begin
      cmd_ready = ($urandom_range(0, 2) == 0);  // Mostly stalled
      @(posedge clock);
      ok = cmd_valid && cmd_ready;
      #1;
    end
    cmd_ready = 1'b0;
    if (!ok) begin
      $display("Timeout: no read command reached the host port");
      timeout_count++;
    end
  endtask

  task automatic wait_desc(input logic level, output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < MAX_WAIT && !ok; n++) begin
      @(posedge clock);
      ok = (wed_valid == level);
      #1;
    end
    if (!ok) begin
      $display("Timeout: wed_valid never went to %0d", level);
      timeout_count++;
    end
  endtask

  task automatic send_beat(input logic [7:0] tag, input logic half, input logic [511:0] data);
    rd_valid = 1'b1;
    rd_tag   = tag;
    rd_half  = half;
    rd_data  = data;
    step();
    rd_valid = 1'b0;
  endtask

  task automatic send_response(input logic [7:0] tag, input logic [1:0] code);
    rsp_valid = 1'b1;
    rsp_tag   = tag;
    rsp_code  = code;
    step();
    rsp_valid = 1'b0;
  endtask

  task automatic run_case(input wed_case_t c);
    bit ok;
    bit upper_first;
    int attempt;
    wed_address = c.address;
    enable      = 1'b1;
    for (attempt = 0; attempt < (c.fail_first ? 2 : 1); attempt++) begin
      wait_command(ok);
      if (!ok) return;
      upper_first = ($urandom_range(0, 1) == 1);
      send_beat(WED_TAG, upper_first, upper_first ? c.upper : c.lower);
      send_response(WED_TAG + 8'd1, RESP_DONE);           // Stray DONE on a half line
      send_beat(WED_TAG, !upper_first, upper_first ? c.lower : c.upper);
      send_beat(WED_TAG + 8'd1, 1'b1, ~c.upper);          // Stray beat after the real upper
      send_response(WED_TAG, (c.fail_first && attempt == 0) ? RESP_FAILED : RESP_DONE);
    end
    wait_desc(1'b1, ok);
    if (!ok) return;
    repeat (4) step();  // Descriptor stays published while enabled
    enable = 1'b0;
    wait_desc(1'b0, ok);
  endtask

  initial begin
    int i;
    void'($urandom(59));
    rstn        = 1'b0;
    enable      = 1'b0;
    wed_address = '0;
    cmd_ready   = 1'b0;
    rd_valid    = 1'b0;
    rd_tag      = '0;
    rd_half     = 1'b0;
    rd_data     = '0;
    rsp_valid   = 1'b0;
    rsp_tag     = '0;
    rsp_code    = '0;
    cur         = '{default: '0};
    load_cases();
    repeat (8) @(posedge clock);
    #1;
    rstn = 1'b1;
    repeat (10) step();  // Port stays quiet with enable low
    for (i = 0; i < cases.size() && timeout_count == 0; i++) begin
      cur = cases[i];
      run_case(cases[i]);
      repeat (2) step();
    end
    $display("Errors: %0d, timeouts: %0d", error_count + file_errors, timeout_count);
    if (error_count == 0 && timeout_count == 0 && file_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* wed_cases.txt */
# Columns: WED address, upper half (fields at the top), lower half, fail-first flag
# Hex values, one case per line
0000000010000000 00000001000004000000180000000003000000002000000000000000200100000000000020080000a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef 0
0000000010000080 000000020000ffff000200008000000100007f000000100000007f000020000000007f00004000000f1e2d3c0f1e2d3c0f1e2d3c0f1e2d3c0f1e2d3c0f1e2d3c 5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a 1
ffffffff00000000 deadbeefcafef00d1234567800000000ffffffffffffff8080000000000000000123456789abcdef000000000000000000000000000000000000000000000000 fedcba9876543210fedcba9876543210fedcba9876543210fedcba9876543210fedcba9876543210fedcba9876543210fedcba9876543210fedcba9876543210 0
0000123456789a00 00000004000000100000002000000000f000000003000000000000000300010000000000300020005a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a 11111111222222221111111122222222111111112222222211111111222222221111111122222222111111112222222211111111222222221111111122222222 1
0000000010000100 7fffffff0000000100000000ffffffff111111111111111122222222222222223333333333333333c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3 a5a5a5a55a5a5a5aa5a5a5a55a5a5a5aa5a5a5a55a5a5a5aa5a5a5a55a5a5a5aa5a5a5a55a5a5a5aa5a5a5a55a5a5a5aa5a5a5a55a5a5a5aa5a5a5a55a5a5a5a 0
00000000deadbe80 0000beef00010000001000000000001100000000c000000000000000c010000000000000c0200000ffffffffffffffffffffffffffffffffffffffffffffffff 80402010080402018040201008040201804020100804020180402010080402018040201008040201804020100804020180402010080402018040201008040201 1

/* src.f */
wed_pkg.sv
wed_bus_if.sv
command_fifo.sv
response_router.sv
wed_control.sv
wed_fetch_top.sv
wed_checker.sv
tb_wed_fetch.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the WED fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f src.f \
  --top-module tb_wed_fetch --Mdir obj_dir -o tb_wed_fetch
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_wed_fetch > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation run exited with status $status"
  exit 1
fi

if grep -q "^Simulation PASSED$" sim.log; then
  exit 0
fi
exit 1
